// ==== ax_arith_pkg.sv ====
package ax_arith_pkg;

    // Activation coming from the previous layer, unsigned.
    typedef logic [7:0] pixel_t;

    // Kernel weight, unsigned to match the multiplier.
    typedef logic [7:0] weight_t;

    // Approximate 8x8 product.
    typedef logic [15:0] product_t;

    // Running sum across the beats of one output pixel. The sum wraps modulo 2^24.
    typedef logic [23:0] acc_t;

endpackage

// ==== pe_cfg_pkg.sv ====
package pe_cfg_pkg;

    // One 3x3 window of one input channel per beat.
    localparam int DEF_KERNEL_TAPS = 9;

    // Scale applied to the finished sum before saturation.
    localparam int DEF_OUT_SHIFT = 8;

    // Width of one beat's sum: product width plus growth for the tap count.
    localparam int TREE_W = 16 + $clog2(DEF_KERNEL_TAPS);

endpackage

// ==== approx_mult_8x8.sv ====
`timescale 1ns/1ps

module approx_mult_8x8 import ax_arith_pkg::*; (
    input  pixel_t   x,
    input  weight_t  y,
    output product_t z
);

    logic [7:0][7:0] row;
    logic [10:0]     word1;
    logic [10:0]     word2;
    logic [10:0]     word3;
    logic [10:0]     word4;
    logic [10:0]     word5;

    always_comb begin
        for (int k = 0; k < 8; k++) begin
            row[k] = y & {8{x[k]}};
        end
    end

    // The four low rows are never added. These words stand in for them.
    always_comb begin
        word1 = '0;
        word2 = '0;
        word3 = '0;
        word4 = '0;
        word5 = '0;

        word1[3]  = row[0][3] ^ row[1][2];
        word1[5]  = row[2][3] ^ row[3][2];
        word1[6]  = row[0][6] & row[1][5]; // Carry of the pair.
        word1[7]  = row[0][6] | row[1][5];
        word1[8]  = row[1][7];
        word1[9]  = row[2][7] | row[3][6];
        word1[10] = row[3][7];

        word2[7] = row[0][7] | row[1][6];
        word2[8] = row[2][6] & row[3][5];

        word3[7] = row[2][4] | row[3][3];
        word3[8] = row[2][6] | row[3][5];

        word4[7] = row[2][5] & row[3][4];

        word5[7] = row[2][5] | row[3][4];
    end

    // Upper rows are exact, the correction words replace the rest.
    always_comb begin
        z = (product_t'(row[4]) << 4)
          + (product_t'(row[5]) << 5)
          + (product_t'(row[6]) << 6)
          + (product_t'(row[7]) << 7)
          + product_t'(word1)
          + product_t'(word2)
          + product_t'(word3)
          + product_t'(word4)
          + product_t'(word5);
    end

endmodule

// ==== tap_product_if.sv ====
`timescale 1ns/1ps

interface tap_product_if import ax_arith_pkg::*, pe_cfg_pkg::*; #(
    parameter int KERNEL_TAPS = DEF_KERNEL_TAPS
);

    logic                        valid;
    logic                        first;
    logic                        last;
    product_t [KERNEL_TAPS-1:0]  products;

    modport producer (
        output valid,
        output first,
        output last,
        output products
    );

    modport consumer (
        input valid,
        input first,
        input last,
        input products
    );

endinterface

// ==== tap_multiplier.sv ====
`timescale 1ns/1ps

module tap_multiplier import ax_arith_pkg::*, pe_cfg_pkg::*; #(
    parameter int KERNEL_TAPS = DEF_KERNEL_TAPS
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid,
    input  logic                        first,
    input  logic                        last,
    input  pixel_t  [KERNEL_TAPS-1:0]   pixels,
    input  weight_t [KERNEL_TAPS-1:0]   weights,
    tap_product_if.producer             prod
);

    product_t [KERNEL_TAPS-1:0] raw_products;

    for (genvar t = 0; t < KERNEL_TAPS; t++) begin : g_tap
        approx_mult_8x8 i_mult (
            .x (pixels[t]),
            .y (weights[t]),
            .z (raw_products[t])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod.valid    <= 1'b0;
            prod.first    <= 1'b0;
            prod.last     <= 1'b0;
            prod.products <= '0;
        end else begin
            prod.valid <= valid;
            prod.first <= valid && first; // Markers only count on real beats.
            prod.last  <= valid && last;
            if (valid) begin
                prod.products <= raw_products; // Hold on idle cycles.
            end
        end
    end

endmodule

// ==== channel_accumulator.sv ====
`timescale 1ns/1ps

module channel_accumulator import ax_arith_pkg::*, pe_cfg_pkg::*; #(
    parameter int KERNEL_TAPS = DEF_KERNEL_TAPS,
    parameter int OUT_SHIFT   = DEF_OUT_SHIFT
) (
    input  logic             clk,
    input  logic             rst_n,
    tap_product_if.consumer  prod,
    output logic             out_valid,
    output pixel_t           out_data
);

    logic [TREE_W-1:0] beat_sum;
    acc_t              acc;
    acc_t              next_total;
    acc_t              shifted;
    logic              group_open;
    logic              accept;
    pixel_t            sat_data;

    always_comb begin
        beat_sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            beat_sum = beat_sum + TREE_W'(prod.products[t]);
        end
    end

    // A first beat drops whatever was collected before it.
    assign accept     = prod.valid && (prod.first || group_open);
    assign next_total = prod.first ? acc_t'(beat_sum) : acc + acc_t'(beat_sum);
    assign shifted    = next_total >> OUT_SHIFT;

    always_comb begin
        if (shifted > acc_t'({$bits(pixel_t){1'b1}})) begin
            sat_data = '1; // Clip to the largest activation.
        end else begin
            sat_data = pixel_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc        <= '0;
            group_open <= 1'b0;
            out_valid  <= 1'b0;
            out_data   <= '0;
        end else begin
            out_valid <= 1'b0;
            if (accept) begin
                acc        <= next_total;
                group_open <= !prod.last;
                if (prod.last) begin
                    out_valid <= 1'b1;
                    out_data  <= sat_data;
                end
            end
        end
    end

endmodule

// ==== conv_pe_top.sv ====
`timescale 1ns/1ps

module conv_pe_top import ax_arith_pkg::*, pe_cfg_pkg::*; #(
    parameter int KERNEL_TAPS = DEF_KERNEL_TAPS,
    parameter int OUT_SHIFT   = DEF_OUT_SHIFT
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic                        in_first,
    input  logic                        in_last,
    input  pixel_t  [KERNEL_TAPS-1:0]   in_pixels,
    input  weight_t [KERNEL_TAPS-1:0]   in_weights,
    output logic                        out_valid,
    output pixel_t                      out_data
);

    tap_product_if #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) i_prod_if ();

    tap_multiplier #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) i_mult (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (in_valid),
        .first   (in_first),
        .last    (in_last),
        .pixels  (in_pixels),
        .weights (in_weights),
        .prod    (i_prod_if.producer)
    );

    channel_accumulator #(
        .KERNEL_TAPS (KERNEL_TAPS),
        .OUT_SHIFT   (OUT_SHIFT)
    ) i_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .prod      (i_prod_if.consumer),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// Approximate product: exact upper rows plus the correction bits for the low rows.
function automatic logic [15:0] approx_ref(input logic [7:0] x, input logic [7:0] y);
    logic [7:0]  r0;
    logic [7:0]  r1;
    logic [7:0]  r2;
    logic [7:0]  r3;
    logic [31:0] total;
    r0 = x[0] ? y : 8'h00;
    r1 = x[1] ? y : 8'h00;
    r2 = x[2] ? y : 8'h00;
    r3 = x[3] ? y : 8'h00;
    total = 32'd0;
    for (int k = 4; k < 8; k++) begin
        if (x[k]) begin
            total = total + ({24'd0, y} << k);
        end
    end
    total = total + (32'(r0[3] ^ r1[2]) << 3);
    total = total + (32'(r2[3] ^ r3[2]) << 5);
    total = total + (32'(r0[6] & r1[5]) << 6);
    total = total + (32'(r0[6] | r1[5]) << 7);
    total = total + (32'(r1[7]) << 8);
    total = total + (32'(r2[7] | r3[6]) << 9);
    total = total + (32'(r3[7]) << 10);
    total = total + (32'(r0[7] | r1[6]) << 7);         // Second word.
    total = total + (32'(r2[6] & r3[5]) << 8);
    total = total + (32'(r2[4] | r3[3]) << 7);         // Third word.
    total = total + (32'(r2[6] | r3[5]) << 8);
    total = total + (32'(r2[5] & r3[4]) << 7);         // Fourth and fifth words.
    total = total + (32'(r2[5] | r3[4]) << 7);
    return total[15:0];
endfunction

// Output pixel of one group: 24-bit running sum, shifted and clipped to 255.
function automatic logic [7:0] group_ref(
    input int         n_beats,
    input logic [7:0] pix [GROUP_MAX][KERNEL_N],
    input logic [7:0] wt  [GROUP_MAX][KERNEL_N],
    input int         shift
);
    logic [23:0] acc;
    logic [23:0] scaled;
    acc = 24'd0;
    for (int b = 0; b < n_beats; b++) begin
        for (int t = 0; t < KERNEL_N; t++) begin
            acc = acc + {8'd0, approx_ref(pix[b][t], wt[b][t])};
        end
    end
    scaled = acc >> shift;
    if (scaled > 24'd255) begin
        return 8'hff;
    end else begin
        return scaled[7:0];
    end
endfunction

// Galois LFSR, shifting right. The output bit is state[0] before the step.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
        return {1'b0, state[31:1]} ^ 32'h8020_0003;
    end else begin
        return {1'b0, state[31:1]};
    end
endfunction

`endif

// ==== tb_conv_pe.sv ====
`timescale 1ns/1ps

module tb_conv_pe import ax_arith_pkg::*; ();

    localparam int          KERNEL_N      = 9;
    localparam int          OUT_SHIFT     = 8;
    localparam int          GROUP_MAX     = 16;
    localparam int          DRAIN_TIMEOUT = 100;
    localparam int          SMALL_WT_BITS = 4; // Narrow weights keep most group sums in range.
    localparam logic [31:0] SEED          = 32'h9f1a_39dc;

    `include "tb_ref.svh"

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_first;
    logic                     in_last;
    pixel_t  [KERNEL_N-1:0]   in_pixels;
    weight_t [KERNEL_N-1:0]   in_weights;
    logic                     out_valid;
    pixel_t                   out_data;

    logic [31:0]              lfsr_state;
    pixel_t  [KERNEL_N-1:0]   stim_pix;
    weight_t [KERNEL_N-1:0]   stim_wt;
    pixel_t                   beat_pix [GROUP_MAX][KERNEL_N];
    weight_t                  beat_wt  [GROUP_MAX][KERNEL_N];
    int                       grp_len;
    logic                     grp_open;
    int                       cycle_cnt;
    pixel_t                   exp_data_q [$];
    int                       exp_cycle_q [$];
    int                       err_cnt;
    int                       check_cnt;

    conv_pe_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_first   (in_first),
        .in_last    (in_last),
        .in_pixels  (in_pixels),
        .in_weights (in_weights),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic fill_random(input logic [7:0] floor_bits, input int wt_bits);
        logic [31:0] r;
        for (int t = 0; t < KERNEL_N; t++) begin
            rand_bits(8, r);
            stim_pix[t] = r[7:0] | floor_bits;
            rand_bits(wt_bits, r);
            stim_wt[t] = r[7:0] | floor_bits;
        end
    endtask

    // Drives one beat and tracks the open group the same way the PE should.
    task automatic send_beat(input logic first, input logic last);
        @(negedge clk);
        in_valid   = 1'b1;
        in_first   = first;
        in_last    = last;
        in_pixels  = stim_pix;
        in_weights = stim_wt;
        if (first) begin
            grp_open = 1'b1;
            grp_len  = 0;
        end
        if (grp_open) begin
            for (int t = 0; t < KERNEL_N; t++) begin
                beat_pix[grp_len][t] = stim_pix[t];
                beat_wt[grp_len][t]  = stim_wt[t];
            end
            grp_len++;
            if (last) begin
                exp_data_q.push_back(group_ref(grp_len, beat_pix, beat_wt, OUT_SHIFT));
                exp_cycle_q.push_back(cycle_cnt + 2); // Two registers in the path.
                grp_open = 1'b0;
            end
        end
    endtask

    // Invalid cycle with junk data and markers.
    task automatic idle_cycle();
        logic [31:0] r;
        fill_random(8'h00, 8);
        rand_bits(2, r);
        @(negedge clk);
        in_valid   = 1'b0;
        in_first   = r[0];
        in_last    = r[1];
        in_pixels  = stim_pix;
        in_weights = stim_wt;
    endtask

    task automatic send_uniform(input logic [7:0] x, input logic [7:0] y);
        for (int t = 0; t < KERNEL_N; t++) begin
            stim_pix[t] = x;
            stim_wt[t]  = y;
        end
        send_beat(1'b1, 1'b1);
    endtask

    always @(negedge clk) begin
        pixel_t exp_data;
        int     exp_cycle;
        if (!rst_n) begin
            assert (!out_valid) else begin
                err_cnt++;
                $display("out_valid went high during reset at %0t", $time);
            end
        end else if (out_valid) begin
            assert (exp_data_q.size() != 0) else begin
                err_cnt++;
                $display("Unexpected out_valid pulse at %0t with no last beat pending", $time);
            end
            if (exp_data_q.size() != 0) begin
                exp_data  = exp_data_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                check_cnt++;
                assert (out_data == exp_data) else begin
                    err_cnt++;
                    $display("ERR %0t: out_data expected %0d, received %0d",
                             $time, exp_data, out_data);
                end
                assert (cycle_cnt == exp_cycle) else begin
                    err_cnt++;
                    $display("out_valid came at cycle %0d instead of cycle %0d",
                             cycle_cnt, exp_cycle);
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          n;
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_first   = 1'b0;
        in_last    = 1'b0;
        in_pixels  = '0;
        in_weights = '0;
        stim_pix   = '0;
        stim_wt    = '0;
        lfsr_state = SEED;
        grp_open   = 1'b0;
        grp_len    = 0;
        cycle_cnt  = 0;
        err_cnt    = 0;
        check_cnt  = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Same pair on every tap, so each row and correction bit shows in the sum.
        send_uniform(8'h00, 8'h00);
        send_uniform(8'hff, 8'hff);
        for (int k = 0; k < 8; k++) begin
            send_uniform(8'h01 << k, 8'hff);
            send_uniform(8'hff, 8'h01 << k);
        end
        for (int x = 0; x < 16; x++) begin
            send_uniform(8'(x), 8'hff);
            send_uniform(8'(x), 8'ha5);
        end

        for (int g = 0; g < 40; g++) begin
            rand_bits(3, r);
            n = int'(r[2:0]) + 1;
            for (int b = 0; b < n; b++) begin
                fill_random(8'h00, SMALL_WT_BITS);
                send_beat(b == 0, b == n - 1);
            end
        end

        for (int g = 0; g < 4; g++) begin
            for (int b = 0; b < GROUP_MAX; b++) begin
                fill_random(8'hc0, 8); // Large operands push the sum past 255.
                send_beat(b == 0, b == GROUP_MAX - 1);
            end
        end

        for (int g = 0; g < 10; g++) begin
            fill_random(8'h00, SMALL_WT_BITS);
            send_beat(1'b0, 1'b1); // Stray last with no group open.
            for (int b = 0; b < 4; b++) begin
                rand_bits(1, r);
                if (r[0]) begin
                    idle_cycle();
                end
                fill_random(8'h00, SMALL_WT_BITS);
                send_beat(b == 0, b == 3);
            end
        end

        for (int g = 0; g < 5; g++) begin
            for (int b = 0; b < 4; b++) begin
                fill_random(8'h00, SMALL_WT_BITS);
                send_beat(b == 0 || b == 2, b == 3); // Second first restarts the sum.
            end
        end

        idle_cycle();
        for (int i = 0; i < DRAIN_TIMEOUT && exp_data_q.size() != 0; i++) begin
            @(posedge clk);
        end
        if (exp_data_q.size() != 0) begin
            err_cnt++;
            $display("Timeout: %0d expected outputs never appeared", exp_data_q.size());
        end
        repeat (10) @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
ax_arith_pkg.sv
pe_cfg_pkg.sv
approx_mult_8x8.sv
tap_product_if.sv
tap_multiplier.sv
channel_accumulator.sv
conv_pe_top.sv
tb_conv_pe.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_conv_pe
RTL_TOP    := conv_pe_top
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
